/* dram_sched.f */
hw/dram_sched_pkg.sv
hw/bus_timing_guard.sv
hw/bank_age_tracker.sv
hw/cas_picker.sv
hw/ras_picker.sv
hw/cmd_arbiter.sv
hw/dram_sched.sv
testbench/dram_sched_assert.sv
testbench/tb_dram_sched.sv

/* Makefile */
TOP = tb_dram_sched

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f dram_sched.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* testbench/tb_dram_sched.sv */
`timescale 1ns/10ps

module tb_dram_sched
    import dram_sched_pkg::*;
();

    localparam int BANK_CNT    = 4;
    localparam int STIM_CYCLES = 2000;
    // Reset, directed phase and drain fit well inside the margin
    localparam int CYCLE_LIMIT = STIM_CYCLES + 500;
    localparam int WAIT_LIMIT  = 400;

    logic                     clk;
    logic                     rst_n;
    bank_req_t [BANK_CNT-1:0] bank_reqs;
    timing_cfg_t              timing_cfg;
    bank_gnt_t [BANK_CNT-1:0] bank_gnts;
    sched_cmd_t               sched_cmd;

    // Bank-controller model
    logic [BANK_CNT-1:0]      busy;
    logic [BANK_CNT-1:0]      granted;
    int                       wait_cnt [BANK_CNT];
    seq_num_t                 next_seq;
    integer                   seed;
    int                       field_errs;
    int                       wait_errs;
    int                       cycle_cnt = 0;

    dram_sched #(.BANK_CNT(BANK_CNT)) DUT (.*);

    bind dram_sched dram_sched_assert #(.BANK_CNT(BANK_CNT)) u_assert (
        .clk        (clk),
        .rst_n      (rst_n),
        .bank_reqs  (bank_reqs),
        .timing_cfg (timing_cfg),
        .bank_gnts  (bank_gnts),
        .sched_cmd  (sched_cmd)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // --------------------
    // Model tasks
    // --------------------
    // Class 0-4 read, 5 write, 6-7 precharge, 8 activate, 9 refresh
    task automatic fill_request(input int b, input int cls);
        bank_reqs[b]         = '0;
        bank_reqs[b].rd_req  = (cls < 5);
        bank_reqs[b].wr_req  = (cls == 5);
        bank_reqs[b].pre_req = (cls == 6) || (cls == 7);
        bank_reqs[b].act_req = (cls == 8);
        bank_reqs[b].ref_req = (cls == 9);
        bank_reqs[b].seq_num = next_seq;
        bank_reqs[b].id      = axi_id_t'($random(seed));
        bank_reqs[b].len     = len_t'($random(seed));
        bank_reqs[b].ra      = row_t'($random(seed));
        bank_reqs[b].ca      = col_t'($random(seed));
        next_seq++;
        busy[b]     = 1'b1;
        wait_cnt[b] = 0;
    endtask

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        if (exp !== got) begin
            field_errs++;
            $display("Fail t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, got);
        end
    endtask

    // Sampled mid-cycle, after inputs and flops have settled
    task automatic check_grant();
        int   b;
        logic cas;
        b = -1;
        for (int i = 0; i < BANK_CNT; i++) begin
            if (bank_gnts[i] != '0)
                b = i;
        end
        if (b >= 0) begin
            // Column command if the model's request for that bank is RD or WR
            cas = bank_reqs[b].rd_req || bank_reqs[b].wr_req;
            check_field("sched_cmd.ra", 32'(bank_reqs[b].ra), 32'(sched_cmd.ra));
            check_field("sched_cmd.ca", 32'(bank_reqs[b].ca), 32'(sched_cmd.ca));
            // Burst info only travels with RD and WR
            check_field("sched_cmd.id", cas ? 32'(bank_reqs[b].id) : 32'd0,
                        32'(sched_cmd.id));
            check_field("sched_cmd.len", cas ? 32'(bank_reqs[b].len) : 32'd0,
                        32'(sched_cmd.len));
            granted[b] = 1'b1;
        end
        for (int i = 0; i < BANK_CNT; i++) begin
            if (busy[i] && !granted[i]) begin
                wait_cnt[i]++;
                if (wait_cnt[i] == WAIT_LIMIT + 1) begin
                    wait_errs++;
                    $display("Bank %0d request held over %0d cycles without a grant",
                             i, WAIT_LIMIT);
                end
            end
        end
    endtask

    // Mode 0 no new work, 1 random refill, 2 lone read on bank 0
    task automatic run_cycle(input int mode);
        @(posedge clk);
        #1;
        for (int i = 0; i < BANK_CNT; i++) begin
            // Granted last cycle, so drop it
            if (granted[i]) begin
                bank_reqs[i] = '0;
                busy[i]      = 1'b0;
            end
            if (!busy[i] && (mode == 1) && ($unsigned($random(seed)) % 4 != 0))
                fill_request(i, int'($unsigned($random(seed)) % 10));
        end
        if ((mode == 2) && !busy[0])
            fill_request(0, 0);
        granted = '0;
        @(negedge clk);
        check_grant();
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        seed       = 60;
        next_seq   = '0;
        field_errs = 0;
        wait_errs  = 0;
        rst_n      = 1'b0;
        bank_reqs  = '0;
        busy       = '0;
        granted    = '0;
        timing_cfg = '{t_rrd_m1: 5'd3, t_ccd_m1: 5'd1, burst_cycle_m2: 5'd2,
                       t_wtr_m1: 5'd4, t_rtw_m1: 5'd2};
        for (int i = 0; i < BANK_CNT; i++)
            wait_cnt[i] = 0;

        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;

        // Quiet bus, then one read with all timers expired
        repeat (5) run_cycle(0);
        run_cycle(2);
        repeat (5) run_cycle(0);

        repeat (STIM_CYCLES) run_cycle(1);

        // Let held requests finish
        while (busy != '0)
            run_cycle(0);
        repeat (5) run_cycle(0);

        $display("Errors: %0d field, %0d wait, %0d assertion",
                 field_errs, wait_errs, DUT.u_assert.err_cnt);
        if ((field_errs + wait_errs + DUT.u_assert.err_cnt) == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* testbench/dram_sched_assert.sv */
`timescale 1ns/10ps

module dram_sched_assert
    import dram_sched_pkg::*;
#(
    parameter int BANK_CNT = 4
)
(
    input logic                     clk,
    input logic                     rst_n,
    input bank_req_t [BANK_CNT-1:0] bank_reqs,
    input timing_cfg_t              timing_cfg,
    input bank_gnt_t [BANK_CNT-1:0] bank_gnts,
    input sched_cmd_t               sched_cmd
);

    // Read by the testbench at the end of the run
    int         err_cnt = 0;

    // Cycles since the last grant of each kind, saturating
    logic [6:0] since_act;
    logic [6:0] since_cas;
    logic [6:0] since_rd;
    logic [6:0] since_wr;
    // CAS grants since the last RAS grant, while RAS work waits
    logic [2:0] cas_run;
    logic [5:0] ccd_gap;
    logic       is_cas;
    logic       is_ras;
    logic       pre_held;
    logic       ras_held;
    logic       rd_any;
    logic       gnt_hit;
    int         req_cnt;

    function automatic logic [6:0] next_gap(input logic [6:0] gap, input logic hit);
        if (hit)
            return 7'd1;
        return (gap == '1) ? gap : gap + 1'b1;
    endfunction

    assign ccd_gap = {1'b0, timing_cfg.t_ccd_m1} + {1'b0, timing_cfg.burst_cycle_m2};
    assign is_cas  = (sched_cmd.cmd == CMD_RD) || (sched_cmd.cmd == CMD_WR);
    assign is_ras  = (sched_cmd.cmd == CMD_PRE) || (sched_cmd.cmd == CMD_ACT) ||
                     (sched_cmd.cmd == CMD_REF);

    // --------------------
    // Request summary and grant match
    // --------------------
    always_comb begin
        pre_held = 1'b0;
        ras_held = 1'b0;
        rd_any   = 1'b0;
        req_cnt  = 0;
        gnt_hit  = (sched_cmd.cmd == CMD_NONE) && (bank_gnts == '0);
        for (int i = 0; i < BANK_CNT; i++) begin
            pre_held = pre_held | bank_reqs[i].pre_req;
            ras_held = ras_held | bank_reqs[i].pre_req | bank_reqs[i].act_req |
                       bank_reqs[i].ref_req;
            rd_any   = rd_any | bank_reqs[i].rd_req;
            if (bank_reqs[i].act_req || bank_reqs[i].pre_req || bank_reqs[i].ref_req ||
                bank_reqs[i].rd_req || bank_reqs[i].wr_req)
                req_cnt++;
            // Granted bank must ask for exactly this command
            if (bank_t'(i) == sched_cmd.ba) begin
                case (sched_cmd.cmd)
                    CMD_ACT: gnt_hit = bank_gnts[i].act_gnt && bank_reqs[i].act_req;
                    CMD_PRE: gnt_hit = bank_gnts[i].pre_gnt && bank_reqs[i].pre_req;
                    CMD_REF: gnt_hit = bank_gnts[i].ref_gnt && bank_reqs[i].ref_req;
                    CMD_RD:  gnt_hit = bank_gnts[i].rd_gnt && bank_reqs[i].rd_req;
                    CMD_WR:  gnt_hit = bank_gnts[i].wr_gnt && bank_reqs[i].wr_req;
                    default: ;
                endcase
            end
        end
    end

    // Nothing granted before reset, so all gaps start long
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            since_act <= '1;
            since_cas <= '1;
            since_rd  <= '1;
            since_wr  <= '1;
            cas_run   <= '0;
        end else begin
            since_act <= next_gap(since_act, sched_cmd.cmd == CMD_ACT);
            since_cas <= next_gap(since_cas, is_cas);
            since_rd  <= next_gap(since_rd, sched_cmd.cmd == CMD_RD);
            since_wr  <= next_gap(since_wr, sched_cmd.cmd == CMD_WR);
            if (is_ras)
                cas_run <= '0;
            else if (is_cas && ras_held && (cas_run != '1))
                cas_run <= cas_run + 1'b1;
        end
    end

    // --------------------
    // Properties
    // --------------------
    a_grant: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(bank_gnts) && gnt_hit)
        else begin err_cnt++; $error("grant does not match command or request"); end

    a_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (req_cnt == 0) |-> (sched_cmd.cmd == CMD_NONE))
        else begin err_cnt++; $error("grant issued with no request"); end

    a_lone_rd: assert property (@(posedge clk) disable iff (!rst_n)
        ((req_cnt == 1) && rd_any && (since_cas > 7'(ccd_gap)) &&
         (since_wr > 7'(timing_cfg.t_wtr_m1))) |-> (sched_cmd.cmd == CMD_RD))
        else begin err_cnt++; $error("lone read not granted in its cycle"); end

    a_rrd: assert property (@(posedge clk) disable iff (!rst_n)
        (sched_cmd.cmd == CMD_ACT) |-> (since_act > 7'(timing_cfg.t_rrd_m1)))
        else begin err_cnt++; $error("ACT to ACT spacing too short"); end

    a_ccd: assert property (@(posedge clk) disable iff (!rst_n)
        is_cas |-> (since_cas > 7'(ccd_gap)))
        else begin err_cnt++; $error("CAS to CAS spacing too short"); end

    a_wtr: assert property (@(posedge clk) disable iff (!rst_n)
        (sched_cmd.cmd == CMD_RD) |-> (since_wr > 7'(timing_cfg.t_wtr_m1)))
        else begin err_cnt++; $error("WR to RD turnaround too short"); end

    a_rtw: assert property (@(posedge clk) disable iff (!rst_n)
        (sched_cmd.cmd == CMD_WR) |-> (since_rd > 7'(timing_cfg.t_rtw_m1)))
        else begin err_cnt++; $error("RD to WR turnaround too short"); end

    // Held PRE must get through within the CAS budget
    a_budget: assert property (@(posedge clk) disable iff (!rst_n)
        (is_cas && pre_held) |-> (32'(cas_run) < CAS_PRIO_LIMIT))
        else begin err_cnt++; $error("CAS run exceeded budget while PRE waited"); end

endmodule

/* hw/dram_sched.sv */
`timescale 1ns/10ps

module dram_sched
    import dram_sched_pkg::*;
#(
    parameter int BANK_CNT = 4
)
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  bank_req_t [BANK_CNT-1:0]   bank_reqs,
    input  timing_cfg_t                timing_cfg,
    output bank_gnt_t [BANK_CNT-1:0]   bank_gnts,
    output sched_cmd_t                 sched_cmd
);

    // Bus timing flags
    logic                  act_ok;
    logic                  rd_ok;
    logic                  wr_ok;
    // Shared picker inputs
    age_t [BANK_CNT-1:0]   ages;
    bank_t                 rr_ptr;
    // CAS candidate
    logic                  cas_valid;
    cmd_e                  cas_cmd;
    bank_t                 cas_bank;
    score_t                cas_score;
    // RAS candidate
    logic                  ras_valid;
    logic                  ras_pending;
    cmd_e                  ras_cmd;
    bank_t                 ras_bank;
    score_t                ras_score;
    // Grant feedback
    bank_t                 gnt_bank;
    logic                  gnt_valid;

    assign gnt_valid = (sched_cmd.cmd != CMD_NONE);

    bus_timing_guard u_guard (
        .clk        (clk),
        .rst_n      (rst_n),
        .timing_cfg (timing_cfg),
        .gnt_cmd    (sched_cmd.cmd),
        .act_ok     (act_ok),
        .rd_ok      (rd_ok),
        .wr_ok      (wr_ok)
    );

    bank_age_tracker #(.BANK_CNT(BANK_CNT)) u_age (
        .clk       (clk),
        .rst_n     (rst_n),
        .bank_reqs (bank_reqs),
        .gnt_valid (gnt_valid),
        .gnt_bank  (gnt_bank),
        .ages      (ages)
    );

    cas_picker #(.BANK_CNT(BANK_CNT)) u_cas (
        .bank_reqs (bank_reqs),
        .ages      (ages),
        .rr_ptr    (rr_ptr),
        .rd_ok     (rd_ok),
        .wr_ok     (wr_ok),
        .cas_valid (cas_valid),
        .cas_cmd   (cas_cmd),
        .cas_bank  (cas_bank),
        .cas_score (cas_score)
    );

    ras_picker #(.BANK_CNT(BANK_CNT)) u_ras (
        .bank_reqs   (bank_reqs),
        .ages        (ages),
        .rr_ptr      (rr_ptr),
        .act_ok      (act_ok),
        .ras_valid   (ras_valid),
        .ras_pending (ras_pending),
        .ras_cmd     (ras_cmd),
        .ras_bank    (ras_bank),
        .ras_score   (ras_score)
    );

    cmd_arbiter #(.BANK_CNT(BANK_CNT)) u_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .bank_reqs   (bank_reqs),
        .cas_valid   (cas_valid),
        .cas_cmd     (cas_cmd),
        .cas_bank    (cas_bank),
        .cas_score   (cas_score),
        .ras_valid   (ras_valid),
        .ras_pending (ras_pending),
        .ras_cmd     (ras_cmd),
        .ras_bank    (ras_bank),
        .ras_score   (ras_score),
        .rr_ptr      (rr_ptr),
        .gnt_bank    (gnt_bank),
        .sched_cmd   (sched_cmd),
        .bank_gnts   (bank_gnts)
    );

endmodule

/* hw/cmd_arbiter.sv */
`timescale 1ns/10ps

module cmd_arbiter
    import dram_sched_pkg::*;
#(
    parameter int BANK_CNT = 4
)
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  bank_req_t [BANK_CNT-1:0]   bank_reqs,
    // Best CAS candidate
    input  logic                       cas_valid,
    input  cmd_e                       cas_cmd,
    input  bank_t                      cas_bank,
    input  score_t                     cas_score,
    // Best RAS candidate
    input  logic                       ras_valid,
    input  logic                       ras_pending,
    input  cmd_e                       ras_cmd,
    input  bank_t                      ras_bank,
    input  score_t                     ras_score,
    output bank_t                      rr_ptr,
    output bank_t                      gnt_bank,
    output sched_cmd_t                 sched_cmd,
    output bank_gnt_t [BANK_CNT-1:0]   bank_gnts
);

    localparam int BUDGET_W = $clog2(CAS_PRIO_LIMIT + 1);

    cmd_e                win_cmd;
    bank_t               win_bank;
    bank_req_t           win_req;
    logic                cas_gnt;
    logic                ras_gnt;
    logic [BUDGET_W-1:0] cas_budget;

    // --------------------
    // CAS or RAS
    // --------------------
    always_comb begin
        win_cmd  = CMD_NONE;
        win_bank = '0;
        if (cas_valid && ras_valid) begin
            // Budget spent, or an older RAS bank outscores the CAS bonus
            if ((cas_budget == '0) || (ras_score > cas_score)) begin
                win_cmd  = ras_cmd;
                win_bank = ras_bank;
            end else begin
                win_cmd  = cas_cmd;
                win_bank = cas_bank;
            end
        end else if (cas_valid) begin
            win_cmd  = cas_cmd;
            win_bank = cas_bank;
        end else if (ras_valid) begin
            win_cmd  = ras_cmd;
            win_bank = ras_bank;
        end
    end

    assign cas_gnt  = (win_cmd == CMD_RD) || (win_cmd == CMD_WR);
    assign ras_gnt  = (win_cmd == CMD_PRE) || (win_cmd == CMD_ACT) || (win_cmd == CMD_REF);
    assign gnt_bank = win_bank;

    // --------------------
    // Grant decode
    // --------------------
    always_comb begin
        win_req       = bank_reqs[win_bank];
        sched_cmd.cmd = win_cmd;
        sched_cmd.ba  = win_bank;
        sched_cmd.ra  = win_req.ra;
        sched_cmd.ca  = win_req.ca;
        // Burst info only for column commands
        sched_cmd.id  = cas_gnt ? win_req.id  : '0;
        sched_cmd.len = cas_gnt ? win_req.len : '0;

        // One pulse to the winning bank only
        for (int i = 0; i < BANK_CNT; i++) begin
            bank_gnts[i].act_gnt = (win_bank == bank_t'(i)) && (win_cmd == CMD_ACT);
            bank_gnts[i].pre_gnt = (win_bank == bank_t'(i)) && (win_cmd == CMD_PRE);
            bank_gnts[i].ref_gnt = (win_bank == bank_t'(i)) && (win_cmd == CMD_REF);
            bank_gnts[i].rd_gnt  = (win_bank == bank_t'(i)) && (win_cmd == CMD_RD);
            bank_gnts[i].wr_gnt  = (win_bank == bank_t'(i)) && (win_cmd == CMD_WR);
        end
    end

    // --------------------
    // Pointer and budget
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr     <= '0;
            cas_budget <= '0;
        end else begin
            // Next search starts after the served bank
            if (win_cmd != CMD_NONE)
                rr_ptr <= (win_bank == bank_t'(BANK_CNT - 1)) ? '0 : win_bank + 1'b1;

            // CAS run consumes budget only while RAS work waits
            if (cas_gnt && ras_pending) begin
                if (cas_budget != '0)
                    cas_budget <= cas_budget - 1'b1;
            end else if (ras_gnt) begin
                cas_budget <= BUDGET_W'(CAS_PRIO_LIMIT);
            end
        end
    end

endmodule

/* hw/ras_picker.sv */
`timescale 1ns/10ps

module ras_picker
    import dram_sched_pkg::*;
#(
    parameter int BANK_CNT = 4
)
(
    input  bank_req_t [BANK_CNT-1:0] bank_reqs,
    input  age_t      [BANK_CNT-1:0] ages,
    input  bank_t                    rr_ptr,
    input  logic                     act_ok,
    output logic                     ras_valid,
    output logic                     ras_pending,
    output cmd_e                     ras_cmd,
    output bank_t                    ras_bank,
    output score_t                   ras_score
);

    // --------------------
    // Best PRE, ACT or REF
    // --------------------
    always_comb begin
        seq_num_t best_seq;
        bank_t    best_dist;

        ras_valid   = 1'b0;
        ras_pending = 1'b0;
        ras_cmd     = CMD_NONE;
        ras_bank    = '0;
        ras_score   = '0;
        best_seq    = '0;
        best_dist   = '0;

        for (int i = 0; i < BANK_CNT; i++) begin
            cmd_e   cand_cmd;
            score_t cand_score;
            bank_t  cand_dist;

            // RAS work waiting, regardless of bus timing
            if (bank_reqs[i].pre_req || bank_reqs[i].act_req || bank_reqs[i].ref_req)
                ras_pending = 1'b1;

            // PRE first, ACT only when tRRD expired, then REF
            cand_cmd = CMD_NONE;
            if (bank_reqs[i].pre_req)
                cand_cmd = CMD_PRE;
            else if (act_ok && bank_reqs[i].act_req)
                cand_cmd = CMD_ACT;
            else if (bank_reqs[i].ref_req)
                cand_cmd = CMD_REF;

            // Pure age, no bonus
            cand_score = score_t'(ages[i]);
            cand_dist  = rr_dist(bank_t'(i), rr_ptr, BANK_CNT);

            if ((cand_cmd != CMD_NONE) &&
                (!ras_valid || cand_beats(cand_score, bank_reqs[i].seq_num, cand_dist,
                                          ras_score, best_seq, best_dist))) begin
                ras_valid = 1'b1;
                ras_cmd   = cand_cmd;
                ras_bank  = bank_t'(i);
                ras_score = cand_score;
                best_seq  = bank_reqs[i].seq_num;
                best_dist = cand_dist;
            end
        end
    end

endmodule

/* hw/cas_picker.sv */
`timescale 1ns/10ps

module cas_picker
    import dram_sched_pkg::*;
#(
    parameter int BANK_CNT = 4
)
(
    input  bank_req_t [BANK_CNT-1:0] bank_reqs,
    input  age_t      [BANK_CNT-1:0] ages,
    input  bank_t                    rr_ptr,
    input  logic                     rd_ok,
    input  logic                     wr_ok,
    output logic                     cas_valid,
    output cmd_e                     cas_cmd,
    output bank_t                    cas_bank,
    output score_t                   cas_score
);

    // --------------------
    // Best RD or WR
    // --------------------
    always_comb begin
        seq_num_t best_seq;
        bank_t    best_dist;

        cas_valid = 1'b0;
        cas_cmd   = CMD_NONE;
        cas_bank  = '0;
        cas_score = '0;
        best_seq  = '0;
        best_dist = '0;

        for (int i = 0; i < BANK_CNT; i++) begin
            cmd_e   cand_cmd;
            score_t cand_score;
            bank_t  cand_dist;

            // Read preferred over write within a bank
            cand_cmd = CMD_NONE;
            if (rd_ok && bank_reqs[i].rd_req)
                cand_cmd = CMD_RD;
            else if (wr_ok && bank_reqs[i].wr_req)
                cand_cmd = CMD_WR;

            // Row hits get a fixed bonus over RAS work
            cand_score = score_t'(ages[i]) + score_t'(CAS_BONUS);
            cand_dist  = rr_dist(bank_t'(i), rr_ptr, BANK_CNT);

            // First candidate wins by default
            if ((cand_cmd != CMD_NONE) &&
                (!cas_valid || cand_beats(cand_score, bank_reqs[i].seq_num, cand_dist,
                                          cas_score, best_seq, best_dist))) begin
                cas_valid = 1'b1;
                cas_cmd   = cand_cmd;
                cas_bank  = bank_t'(i);
                cas_score = cand_score;
                best_seq  = bank_reqs[i].seq_num;
                best_dist = cand_dist;
            end
        end
    end

endmodule

/* hw/bank_age_tracker.sv */
`timescale 1ns/10ps

module bank_age_tracker
    import dram_sched_pkg::*;
#(
    parameter int BANK_CNT = 4
)
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  bank_req_t [BANK_CNT-1:0]   bank_reqs,
    input  logic                       gnt_valid,
    input  bank_t                      gnt_bank,
    output age_t      [BANK_CNT-1:0]   ages
);

    // Any request level from each bank
    logic [BANK_CNT-1:0] pend;

    always_comb begin
        for (int i = 0; i < BANK_CNT; i++) begin
            pend[i] = bank_reqs[i].act_req | bank_reqs[i].pre_req | bank_reqs[i].ref_req |
                      bank_reqs[i].rd_req  | bank_reqs[i].wr_req;
        end
    end

    // Waiting banks grow older until served
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ages <= '0;
        end else begin
            for (int i = 0; i < BANK_CNT; i++) begin
                // Served or idle restarts at zero
                if ((gnt_valid && (gnt_bank == bank_t'(i))) || !pend[i])
                    ages[i] <= '0;
                // Saturate at max
                else if (!(&ages[i]))
                    ages[i] <= ages[i] + 1'b1;
            end
        end
    end

endmodule

/* hw/bus_timing_guard.sv */
`timescale 1ns/10ps

module bus_timing_guard
    import dram_sched_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  timing_cfg_t timing_cfg,
    input  cmd_e        gnt_cmd,
    output logic        act_ok,
    output logic        rd_ok,
    output logic        wr_ok
);

    // CAS spacing covers tCCD plus burst, so one extra bit
    localparam int CCD_W = TMR_W + 1;

    logic [TMR_W-1:0] rrd_cnt;
    logic [CCD_W-1:0] ccd_cnt;
    logic [TMR_W-1:0] wtr_cnt;
    logic [TMR_W-1:0] rtw_cnt;
    logic [CCD_W-1:0] ccd_load;
    logic             cas_gnt;

    assign ccd_load = CCD_W'(timing_cfg.t_ccd_m1) + CCD_W'(timing_cfg.burst_cycle_m2);
    assign cas_gnt  = (gnt_cmd == CMD_RD) || (gnt_cmd == CMD_WR);

    // --------------------
    // Down-counters
    // --------------------
    // Load on grant, else count down and hold at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rrd_cnt <= '0;
            ccd_cnt <= '0;
            wtr_cnt <= '0;
            rtw_cnt <= '0;
        end else begin
            // ACT to ACT, any bank
            if (gnt_cmd == CMD_ACT)
                rrd_cnt <= timing_cfg.t_rrd_m1;
            else if (rrd_cnt != '0)
                rrd_cnt <= rrd_cnt - 1'b1;

            // CAS to CAS, any direction
            if (cas_gnt)
                ccd_cnt <= ccd_load;
            else if (ccd_cnt != '0)
                ccd_cnt <= ccd_cnt - 1'b1;

            // Write to read turnaround
            if (gnt_cmd == CMD_WR)
                wtr_cnt <= timing_cfg.t_wtr_m1;
            else if (wtr_cnt != '0)
                wtr_cnt <= wtr_cnt - 1'b1;

            // Read to write turnaround
            if (gnt_cmd == CMD_RD)
                rtw_cnt <= timing_cfg.t_rtw_m1;
            else if (rtw_cnt != '0)
                rtw_cnt <= rtw_cnt - 1'b1;
        end
    end

    // Eligibility flags for the pickers
    assign act_ok = (rrd_cnt == '0);
    assign rd_ok  = (ccd_cnt == '0) && (wtr_cnt == '0);
    assign wr_ok  = (ccd_cnt == '0) && (rtw_cnt == '0);

endmodule

/* hw/dram_sched_pkg.sv */
package dram_sched_pkg;

    // --------------------
    // Widths
    // --------------------
    // Lower sequence number means older request
    typedef logic [7:0]  seq_num_t;
    typedef logic [3:0]  axi_id_t;
    typedef logic [3:0]  len_t;
    typedef logic [13:0] row_t;
    typedef logic [9:0]  col_t;
    // Room for up to 8 banks
    typedef logic [2:0]  bank_t;
    // Saturating bank age
    typedef logic [7:0]  age_t;
    // Age plus bonus, never overflows
    typedef logic [9:0]  score_t;

    // Timing field width
    localparam int TMR_W = 5;

    // Scoring and CAS budget
    localparam int CAS_BONUS      = 8;
    localparam int CAS_PRIO_LIMIT = 4;

    // --------------------
    // Commands and bundles
    // --------------------
    typedef enum logic [2:0] {
        CMD_NONE,
        CMD_PRE,
        CMD_RD,
        CMD_WR,
        CMD_ACT,
        CMD_REF
    } cmd_e;

    // Request levels from one bank controller
    typedef struct packed {
        logic     act_req;
        logic     pre_req;
        logic     ref_req;
        logic     rd_req;
        logic     wr_req;
        seq_num_t seq_num;
        axi_id_t  id;
        len_t     len;
        row_t     ra;
        col_t     ca;
    } bank_req_t;

    // One-cycle grant pulses back to a bank
    typedef struct packed {
        logic act_gnt;
        logic pre_gnt;
        logic ref_gnt;
        logic rd_gnt;
        logic wr_gnt;
    } bank_gnt_t;

    // Inter-bank bus timing, minus-one encoded
    typedef struct packed {
        logic [TMR_W-1:0] t_rrd_m1;
        logic [TMR_W-1:0] t_ccd_m1;
        logic [TMR_W-1:0] burst_cycle_m2;
        logic [TMR_W-1:0] t_wtr_m1;
        logic [TMR_W-1:0] t_rtw_m1;
    } timing_cfg_t;

    // Command issued to the DRAM this cycle
    typedef struct packed {
        cmd_e    cmd;
        bank_t   ba;
        row_t    ra;
        col_t    ca;
        axi_id_t id;
        len_t    len;
    } sched_cmd_t;

    // --------------------
    // Picker helpers
    // --------------------
    // Distance of a bank from the round-robin pointer, modulo bank count
    function automatic bank_t rr_dist(input bank_t idx, input bank_t ptr,
                                      input int unsigned cnt);
        if (idx >= ptr)
            rr_dist = idx - ptr;
        else
            rr_dist = bank_t'(cnt - ptr + idx);
    endfunction

    // Score first, then older seq_num, then nearer to rr_ptr
    function automatic logic cand_beats(input score_t s_a, input seq_num_t q_a,
                                        input bank_t d_a, input score_t s_b,
                                        input seq_num_t q_b, input bank_t d_b);
        cand_beats = (s_a > s_b) ||
                     ((s_a == s_b) && ((q_a < q_b) || ((q_a == q_b) && (d_a < d_b))));
    endfunction

endpackage
